// File: common/crdt_pkg.sv
package crdt_pkg;

    // ----------------------------------------
    // sizes of the credit interface
    // ----------------------------------------
    localparam int num_classes  = 3;    // P, NP, CPL
    localparam int num_channels = 6;    // header channels first, then data channels

    localparam int len_w      = 10;     // request length in DW
    localparam int hdr_cnt_w  = 2;
    localparam int data_cnt_w = 4;
    localparam int ctr_w      = 16;
    localparam int init_ctr_w = 8;

    localparam int dw_per_credit_log2 = 2;  // 4 DW per data credit

    typedef logic [ctr_w-1:0] ctr_t;

    // per-cycle return limits, sized to the counters they are compared with
    localparam ctr_t max_hdr_ret   = ctr_t'(3);
    localparam ctr_t max_data_ret  = ctr_t'(15);
    localparam ctr_t low_watermark = ctr_t'(3);

    // value doubles as the bit index in the per-class vectors
    typedef enum logic [1:0] {
        P   = 2'd0,
        NP  = 2'd1,
        CPL = 2'd2
    } crdt_class_e;

    typedef enum logic [1:0] {
        RX_INIT     = 2'd0,
        RX_INIT_RET = 2'd1,
        IDLE        = 2'd2,
        TX_INIT_CAP = 2'd3
    } rx_state_e;

    // length in DW to data credits, rounded up
    function automatic ctr_t len_to_credits(input logic [len_w-1:0] len_dw);
        ctr_t whole;
        whole = ctr_t'(len_dw >> dw_per_credit_log2);
        return whole + ctr_t'(|len_dw[dw_per_credit_log2-1:0]);
    endfunction

endpackage

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module crdt_intf_tb -f verilog.f -o crdt_sim \
    && ./obj_dir/crdt_sim > sim.log 2>&1 \
    || echo "build or simulation aborted"

cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log 2>/dev/null && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1

// File: rx_credit/rx_credit_fsm.sv
`timescale 1ns/100ps

module rx_credit_fsm (
    input  logic                clk,
    input  logic                srst_reg,
    input  logic                rx_ready_i,
    input  logic                all_empty_i,
    input  logic                tx_init_any_i,
    output crdt_pkg::rx_state_e rx_state_o
);

    crdt_pkg::rx_state_e state_q;
    crdt_pkg::rx_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            crdt_pkg::RX_INIT: begin
                state_d = crdt_pkg::RX_INIT_RET;       // single cycle
            end
            crdt_pkg::RX_INIT_RET: begin
                // init amounts only drain after every ack, so this waits for all six
                if (all_empty_i && rx_ready_i) begin
                    state_d = crdt_pkg::IDLE;
                end
            end
            crdt_pkg::IDLE: begin
                if (tx_init_any_i) begin
                    state_d = crdt_pkg::TX_INIT_CAP;
                end
            end
            crdt_pkg::TX_INIT_CAP: begin
                if (!tx_init_any_i) begin
                    state_d = crdt_pkg::IDLE;   // transmit init level dropped
                end
            end
            default: begin
                state_d = crdt_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge srst_reg) begin
        if (srst_reg) begin
            state_q <= crdt_pkg::RX_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    assign rx_state_o = state_q;

endmodule

// File: rx_credit/rx_credit_return.sv
`timescale 1ns/100ps

module rx_credit_return #(
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_p_data   = 8'd85,
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_np_data  = 8'd85,
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_cpl_data = 8'd85,
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_p_hdr    = 8'd11,
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_np_hdr   = 8'd11,
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_cpl_hdr  = 8'd10
) (
    input  logic                                                 clk,
    input  logic                                                 srst_reg,
    input  crdt_pkg::rx_state_e                                  rx_state_i,
    input  logic [crdt_pkg::num_classes-1:0]                     rx_hcrdt_init_ack_i,
    input  logic [crdt_pkg::num_classes-1:0]                     rx_dcrdt_init_ack_i,
    input  logic                                                 hdr_valid_i,
    input  logic                                                 hdr_is_rd_i,
    input  logic                                                 hdr_is_wr_i,
    input  logic [crdt_pkg::len_w-1:0]                           hdr_len_i,
    output logic [crdt_pkg::num_classes-1:0]                     rx_hcrdt_init_o,
    output logic [crdt_pkg::num_classes-1:0]                     rx_dcrdt_init_o,
    output logic [crdt_pkg::num_classes-1:0]                     rx_hcrdt_update_o,
    output logic [crdt_pkg::num_classes*crdt_pkg::hdr_cnt_w-1:0] rx_hcrdt_update_cnt_o,
    output logic [crdt_pkg::num_classes-1:0]                     rx_dcrdt_update_o,
    output logic [crdt_pkg::num_classes*crdt_pkg::data_cnt_w-1:0] rx_dcrdt_update_cnt_o,
    output logic                                                 all_empty_o
);

    localparam int nc = crdt_pkg::num_classes;
    localparam int hw = crdt_pkg::hdr_cnt_w;
    localparam int dw = crdt_pkg::data_cnt_w;

    localparam logic [crdt_pkg::init_ctr_w-1:0] hdr_init_val [nc] =
        '{init_rx_p_hdr, init_rx_np_hdr, init_rx_cpl_hdr};
    localparam logic [crdt_pkg::init_ctr_w-1:0] data_init_val [nc] =
        '{init_rx_p_data, init_rx_np_data, init_rx_cpl_data};

    logic [crdt_pkg::init_ctr_w-1:0] hdr_init_amt [nc];    // cleared once acked
    logic [crdt_pkg::init_ctr_w-1:0] data_init_amt [nc];
    crdt_pkg::ctr_t hdr_ctr [nc];
    crdt_pkg::ctr_t data_ctr [nc];
    crdt_pkg::ctr_t hdr_add [nc];
    crdt_pkg::ctr_t data_add [nc];
    crdt_pkg::ctr_t hdr_chunk [nc];
    crdt_pkg::ctr_t data_chunk [nc];
    logic           init_ret;
    logic           hdr_valid_q;
    logic           hdr_is_rd_q;
    logic           hdr_is_wr_q;
    crdt_pkg::ctr_t len_credits_q;

    assign init_ret        = (rx_state_i == crdt_pkg::RX_INIT_RET);
    assign rx_hcrdt_init_o = {nc{init_ret}};
    assign rx_dcrdt_init_o = {nc{init_ret}};

    // ----------------------------------------
    // credits to add and chunk to drain
    // ----------------------------------------
    always_comb begin
        for (int c = 0; c < nc; c++) begin
            hdr_add[c]  = (init_ret && rx_hcrdt_init_ack_i[c]) ?
                          crdt_pkg::ctr_t'(hdr_init_amt[c]) : '0;
            data_add[c] = (init_ret && rx_dcrdt_init_ack_i[c]) ?
                          crdt_pkg::ctr_t'(data_init_amt[c]) : '0;
            hdr_chunk[c]  = (hdr_ctr[c] > crdt_pkg::max_hdr_ret) ?
                            crdt_pkg::max_hdr_ret : hdr_ctr[c];
            data_chunk[c] = (data_ctr[c] > crdt_pkg::max_data_ret) ?
                            crdt_pkg::max_data_ret : data_ctr[c];
        end
        if (hdr_valid_q) begin
            // read gives back one NP header, write one P header plus its payload
            hdr_add[crdt_pkg::NP] = hdr_add[crdt_pkg::NP] + crdt_pkg::ctr_t'(hdr_is_rd_q);
            hdr_add[crdt_pkg::P]  = hdr_add[crdt_pkg::P] + crdt_pkg::ctr_t'(hdr_is_wr_q);
            if (hdr_is_wr_q) begin
                data_add[crdt_pkg::P] = data_add[crdt_pkg::P] + len_credits_q;
            end
        end
    end

    always_comb begin
        all_empty_o = 1'b1;
        for (int c = 0; c < nc; c++) begin
            if (hdr_ctr[c] != '0 || data_ctr[c] != '0 ||
                hdr_init_amt[c] != '0 || data_init_amt[c] != '0) begin
                all_empty_o = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // counters and update outputs
    // ----------------------------------------
    always_ff @(posedge clk or posedge srst_reg) begin
        if (srst_reg) begin
            for (int c = 0; c < nc; c++) begin
                hdr_ctr[c]       <= '0;
                data_ctr[c]      <= '0;
                hdr_init_amt[c]  <= hdr_init_val[c];
                data_init_amt[c] <= data_init_val[c];
            end
            rx_hcrdt_update_o     <= '0;
            rx_hcrdt_update_cnt_o <= '0;
            rx_dcrdt_update_o     <= '0;
            rx_dcrdt_update_cnt_o <= '0;
            hdr_valid_q           <= 1'b0;
            hdr_is_rd_q           <= 1'b0;
            hdr_is_wr_q           <= 1'b0;
            len_credits_q         <= '0;
        end else begin
            hdr_valid_q   <= hdr_valid_i;
            hdr_is_rd_q   <= hdr_is_rd_i;
            hdr_is_wr_q   <= hdr_is_wr_i;
            len_credits_q <= crdt_pkg::len_to_credits(hdr_len_i);
            for (int c = 0; c < nc; c++) begin
                hdr_ctr[c]  <= hdr_ctr[c] - hdr_chunk[c] + hdr_add[c];
                data_ctr[c] <= data_ctr[c] - data_chunk[c] + data_add[c];
                if (init_ret && rx_hcrdt_init_ack_i[c]) begin
                    hdr_init_amt[c] <= '0;
                end
                if (init_ret && rx_dcrdt_init_ack_i[c]) begin
                    data_init_amt[c] <= '0;
                end
                rx_hcrdt_update_o[c] <= (hdr_chunk[c] != '0);
                rx_dcrdt_update_o[c] <= (data_chunk[c] != '0);
                rx_hcrdt_update_cnt_o[c*hw +: hw] <= hdr_chunk[c][hw-1:0];
                rx_dcrdt_update_cnt_o[c*dw +: dw] <= data_chunk[c][dw-1:0];
            end
        end
    end

endmodule

// File: tx_credit/tx_consume_calc.sv
`timescale 1ns/100ps

module tx_consume_calc (
    input  logic                                       clk,
    input  logic                                       srst_reg,
    input  logic                                       tx_hdr_valid_i,
    input  logic [crdt_pkg::len_w-1:0]                 tx_hdr_len_i,
    output crdt_pkg::ctr_t [crdt_pkg::num_channels-1:0] consume_o
);

    // header channels come first, so the CPL data channel sits one class block up
    localparam int cpl_hdr_ch  = int'(crdt_pkg::CPL);
    localparam int cpl_data_ch = crdt_pkg::num_classes + cpl_hdr_ch;

    logic           tx_hdr_valid_q;
    crdt_pkg::ctr_t cpl_credits_q;

    always_ff @(posedge clk or posedge srst_reg) begin
        if (srst_reg) begin
            tx_hdr_valid_q <= 1'b0;
            cpl_credits_q  <= '0;
        end else begin
            tx_hdr_valid_q <= tx_hdr_valid_i;
            cpl_credits_q  <= crdt_pkg::len_to_credits(tx_hdr_len_i);
        end
    end

    always_comb begin
        consume_o = '0;
        if (tx_hdr_valid_q) begin
            consume_o[cpl_hdr_ch]  = crdt_pkg::ctr_t'(1);  // one header per completion
            consume_o[cpl_data_ch] = cpl_credits_q;
        end
    end

endmodule

// File: tx_credit/tx_credit_channel.sv
`timescale 1ns/100ps

module tx_credit_channel (
    input  logic                           clk,
    input  logic                           srst_reg,
    input  logic                           update_i,
    input  logic [crdt_pkg::data_cnt_w-1:0] update_cnt_i,
    input  logic                           init_i,
    input  crdt_pkg::ctr_t                 consume_i,
    output logic                           init_ack_o,
    output logic                           credit_low_o
);

    crdt_pkg::ctr_t credit_ctr;
    crdt_pkg::ctr_t grant;
    logic           infinite_q;
    logic           init_q;         // init level as sampled
    logic           init_seen_q;    // init_q one cycle later, for the rising edge

    assign grant = update_i ? crdt_pkg::ctr_t'(update_cnt_i) : '0;

    always_ff @(posedge clk or posedge srst_reg) begin
        if (srst_reg) begin
            credit_ctr  <= '0;
            infinite_q  <= 1'b0;
            init_q      <= 1'b0;
            init_seen_q <= 1'b0;
            init_ack_o  <= 1'b0;
        end else begin
            credit_ctr <= credit_ctr + grant - consume_i;  // grant and consume may coincide
            // zero count during init advertises unlimited credits
            if (update_i && init_i && update_cnt_i == '0) begin
                infinite_q <= 1'b1;
            end
            init_q      <= init_i;
            init_seen_q <= init_q;
            init_ack_o  <= init_q && !init_seen_q;  // one pulse per init level
        end
    end

    assign credit_low_o = (credit_ctr < crdt_pkg::low_watermark) && !infinite_q;

endmodule

// File: tx_credit/tx_ready_gen.sv
`timescale 1ns/100ps

module tx_ready_gen (
    input  logic                             clk,
    input  logic                             srst_reg,
    input  logic [crdt_pkg::num_channels-1:0] credit_low_i,
    input  logic                             pio_tx_ready_i,
    output logic                             tx_ready_o
);

    // any low channel back-pressures the transmit side
    always_ff @(posedge clk or posedge srst_reg) begin
        if (srst_reg) begin
            tx_ready_o <= 1'b0;
        end else if (|credit_low_i) begin
            tx_ready_o <= 1'b0;
        end else begin
            tx_ready_o <= pio_tx_ready_i;
        end
    end

endmodule

// File: verification/crdt_checks.svh
`ifndef CRDT_CHECKS_SVH
`define CRDT_CHECKS_SVH

// ----------------------------------------
// error counters and compare tasks
// ----------------------------------------
int value_errors   = 0;
int timeout_errors = 0;

localparam int wait_limit = 100;    // cycles before a wait gives up

task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("FAILED %s: got %h, expected %h", name, actual, expected);
        value_errors++;
    end
endtask

task automatic check_count(input string name, input crdt_pkg::ctr_t actual,
                           input crdt_pkg::ctr_t expected);
    if (actual !== expected) begin
        $display("FAILED %s: got %h, expected %h", name, actual, expected);
        value_errors++;
    end
endtask

task automatic check_state_class(input string name, input crdt_pkg::crdt_class_e actual,
                                 input crdt_pkg::crdt_class_e expected);
    if (actual !== expected) begin
        $display("FAILED %s: got %h, expected %h", name, actual, expected);
        value_errors++;
    end
endtask

// ----------------------------------------
// wait loops, each bounded
// ----------------------------------------
task automatic wait_init_level(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while ((rx_hcrdt_init_o != {3{level}} || rx_dcrdt_init_o != {3{level}}) &&
           n < wait_limit) begin
        @(negedge clk);
        n++;
    end
    if (n == wait_limit) begin
        $display("ERROR: receive init levels never reached %0d", level);
        timeout_errors++;
    end
endtask

task automatic wait_tx_ready(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (tx_ready_o !== level && n < wait_limit) begin
        @(negedge clk);
        n++;
    end
    if (n == wait_limit) begin
        $display("ERROR: tx_ready_o did not settle to %0d in time", level);
        timeout_errors++;
    end
endtask

// waits for the first returned chunk, then for the drain to end
task automatic wait_returns_done();
    int n;
    n = 0;
    @(negedge clk);
    while (!(|{rx_hcrdt_update_o, rx_dcrdt_update_o}) && n < wait_limit) begin
        @(negedge clk);
        n++;
    end
    if (n == wait_limit) begin
        $display("ERROR: no credit return started");
        timeout_errors++;
        return;
    end
    n = 0;
    while ((|{rx_hcrdt_update_o, rx_dcrdt_update_o}) && n < wait_limit) begin
        @(negedge clk);
        n++;
    end
    if (n == wait_limit) begin
        $display("ERROR: credit return kept going and never drained");
        timeout_errors++;
    end
endtask

task automatic wait_acks(input logic [5:0] mask);
    int   n;
    logic done;
    n = 0;
    done = 1'b0;
    while (!done && n < wait_limit) begin
        @(negedge clk);
        n++;
        done = 1'b1;
        for (int ch = 0; ch < 6; ch++) begin
            if (mask[ch] && ack_cnt[ch] == ack_base[ch]) begin
                done = 1'b0;
            end
        end
    end
    if (!done) begin
        $display("ERROR: transmit init acks missing for channels %b", mask);
        timeout_errors++;
    end
endtask

`endif

// File: verification/crdt_intf_tb.sv
`timescale 1ns/100ps

module crdt_intf_tb;

    localparam int low_mark       = 3;     // transmit channel watermark

    logic        clk, srst_reg, rx_ready_i, pio_tx_ready_i, tx_ready_o;
    logic        hdr_valid_i, hdr_is_rd_i, hdr_is_wr_i, tx_hdr_valid_i;
    logic [2:0]  rx_hcrdt_init_o, rx_dcrdt_init_o, rx_hcrdt_init_ack_i, rx_dcrdt_init_ack_i;
    logic [2:0]  rx_hcrdt_update_o, rx_dcrdt_update_o, tx_hcrdt_update_i, tx_dcrdt_update_i;
    logic [2:0]  tx_hcrdt_init_i, tx_dcrdt_init_i, tx_hcrdt_init_ack_o, tx_dcrdt_init_ack_o;
    logic [5:0]  rx_hcrdt_update_cnt_o, tx_hcrdt_update_cnt_i;
    logic [11:0] rx_dcrdt_update_cnt_o, tx_dcrdt_update_cnt_i;
    logic [9:0]  hdr_len_i, tx_hdr_len_i;
    logic [5:0]  tx_acks;

    crdt_pkg::ctr_t hdr_sum [3];
    crdt_pkg::ctr_t data_sum [3];
    crdt_pkg::ctr_t hdr_base [3];
    crdt_pkg::ctr_t data_base [3];
    crdt_pkg::ctr_t exp_hdr [3];
    crdt_pkg::ctr_t exp_data [3];
    crdt_pkg::ctr_t ack_cnt [6];
    crdt_pkg::ctr_t ack_base [6];
    crdt_pkg::ctr_t oversize_chunks;
    int             model_ctr [6];     // expected transmit credits per channel
    logic           model_inf [6];
    integer         seed;
    int             rnd;
    logic [9:0]     len;
    crdt_pkg::crdt_class_e got_class;

    // ----------------------------------------
    // stimulus tables
    // ----------------------------------------
    crdt_pkg::ctr_t init_hdr [3]  = '{16'd11, 16'd11, 16'd10};
    crdt_pkg::ctr_t init_data [3] = '{16'd85, 16'd85, 16'd85};
    logic [5:0]     rt_is_wr = 6'b011010;  // bit i set means entry i is a write
    crdt_pkg::crdt_class_e rt_class [6] = '{crdt_pkg::NP, crdt_pkg::P, crdt_pkg::NP,
                                           crdt_pkg::P, crdt_pkg::P, crdt_pkg::NP};
    logic [2:0]     gr_hupd [2] = '{3'b111, 3'b100};
    logic [5:0]     gr_hcnt [2] = '{6'b111111, 6'b110000};
    logic [2:0]     gr_dupd [2] = '{3'b111, 3'b100};
    logic [11:0]    gr_dcnt [2] = '{12'hfff, 12'h500};
    logic [9:0]     cpl_len [3] = '{10'd16, 10'd22, 10'd40};  // last one drains CPL data

    assign tx_acks = {tx_dcrdt_init_ack_o, tx_hcrdt_init_ack_o};

    crdt_intf_top i_dut (.*);

    `include "crdt_checks.svh"

    always #4 clk = ~clk;

    // sums of returned credits and ack pulses
    always @(negedge clk) begin
        if (srst_reg) begin
            for (int c = 0; c < 3; c++) begin
                hdr_sum[c]  <= '0;
                data_sum[c] <= '0;
            end
            for (int ch = 0; ch < 6; ch++) begin
                ack_cnt[ch] <= '0;
            end
            oversize_chunks <= '0;
        end else begin
            for (int c = 0; c < 3; c++) begin
                if (rx_hcrdt_update_o[c]) begin
                    hdr_sum[c] <= hdr_sum[c] + crdt_pkg::ctr_t'(rx_hcrdt_update_cnt_o[c*2 +: 2]);
                end
                if (rx_dcrdt_update_o[c]) begin
                    data_sum[c] <= data_sum[c] + crdt_pkg::ctr_t'(rx_dcrdt_update_cnt_o[c*4 +: 4]);
                end
                // a chunk above 3 header or 15 data credits wraps its field to a zero count
                if ((rx_hcrdt_update_o[c] && rx_hcrdt_update_cnt_o[c*2 +: 2] == 2'd0) ||
                    (rx_dcrdt_update_o[c] && rx_dcrdt_update_cnt_o[c*4 +: 4] == 4'd0)) begin
                    oversize_chunks <= oversize_chunks + crdt_pkg::ctr_t'(1);
                end
            end
            for (int ch = 0; ch < 6; ch++) begin
                ack_cnt[ch] <= ack_cnt[ch] + crdt_pkg::ctr_t'(tx_acks[ch]);
            end
        end
    end

    function automatic logic expect_ready();
        logic rdy;
        rdy = pio_tx_ready_i;
        for (int ch = 0; ch < 6; ch++) begin
            if (!model_inf[ch] && model_ctr[ch] < low_mark) begin
                rdy = 1'b0;
            end
        end
        return rdy;
    endfunction

    task automatic take_snapshot();
        for (int c = 0; c < 3; c++) begin
            hdr_base[c]  = hdr_sum[c];
            data_base[c] = data_sum[c];
            exp_hdr[c]   = '0;
            exp_data[c]  = '0;
        end
        for (int ch = 0; ch < 6; ch++) begin
            ack_base[ch] = ack_cnt[ch];
        end
    endtask

    task automatic check_returns();
        @(posedge clk);
        #1;
        for (int c = 0; c < 3; c++) begin
            check_count($sformatf("rx_hcrdt returned, class %0d", c),
                        hdr_sum[c] - hdr_base[c], exp_hdr[c]);
            check_count($sformatf("rx_dcrdt returned, class %0d", c),
                        data_sum[c] - data_base[c], exp_data[c]);
        end
    endtask

    task automatic check_acks(input logic [5:0] mask);
        wait_acks(mask);
        repeat (3) @(posedge clk);      // room for a stray second pulse
        #1;
        for (int ch = 0; ch < 6; ch++) begin
            check_count($sformatf("init ack pulses, channel %0d", ch),
                        ack_cnt[ch] - ack_base[ch], crdt_pkg::ctr_t'(mask[ch]));
        end
    endtask

    task automatic apply_grant(input logic [2:0] hupd, input logic [5:0] hcnt,
                               input logic [2:0] dupd, input logic [11:0] dcnt);
        @(posedge clk);
        #1;
        tx_hcrdt_update_i     = hupd;
        tx_hcrdt_update_cnt_i = hcnt;
        tx_dcrdt_update_i     = dupd;
        tx_dcrdt_update_cnt_i = dcnt;
        for (int c = 0; c < 3; c++) begin
            if (hupd[c]) begin
                model_ctr[c] += int'(hcnt[c*2 +: 2]);
                model_inf[c] = model_inf[c] | (tx_hcrdt_init_i[c] && hcnt[c*2 +: 2] == 2'd0);
            end
            if (dupd[c]) begin
                model_ctr[3+c] += int'(dcnt[c*4 +: 4]);
                model_inf[3+c] = model_inf[3+c] | (tx_dcrdt_init_i[c] && dcnt[c*4 +: 4] == 4'd0);
            end
        end
        @(posedge clk);
        #1;
        tx_hcrdt_update_i = '0;
        tx_dcrdt_update_i = '0;
    endtask

    // one completion header, then tx_ready_o two edges after it is consumed
    task automatic send_and_check(input logic [9:0] cpl_dw);
        @(posedge clk);
        #1;
        tx_hdr_valid_i = 1'b1;
        tx_hdr_len_i   = cpl_dw;
        model_ctr[2] -= 1;
        model_ctr[5] -= (int'(cpl_dw) + 3) / 4;
        @(posedge clk);
        #1;
        tx_hdr_valid_i = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_bit("tx_ready_o", tx_ready_o, expect_ready());
    endtask

    initial begin
        clk      = 1'b0;
        srst_reg = 1'b1;
        {rx_ready_i, pio_tx_ready_i, hdr_valid_i, hdr_is_rd_i, hdr_is_wr_i} = '0;
        {rx_hcrdt_init_ack_i, rx_dcrdt_init_ack_i, tx_hcrdt_init_i, tx_dcrdt_init_i} = '0;
        {tx_hcrdt_update_i, tx_dcrdt_update_i, tx_hcrdt_update_cnt_i} = '0;
        {tx_dcrdt_update_cnt_i, hdr_len_i, tx_hdr_len_i, tx_hdr_valid_i} = '0;
        seed = 32'hdac2;
        for (int ch = 0; ch < 6; ch++) begin
            model_ctr[ch] = 0;
            model_inf[ch] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        srst_reg = 1'b0;

        // quiet outputs right after reset
        @(negedge clk);
        check_bit("rx_hcrdt_update_o", |rx_hcrdt_update_o, 1'b0);
        check_bit("rx_dcrdt_update_o", |rx_dcrdt_update_o, 1'b0);
        check_bit("tx_init_ack", |tx_acks, 1'b0);
        check_bit("tx_ready_o", tx_ready_o, 1'b0);
        check_bit("rx_hcrdt_init_o", |rx_hcrdt_init_o, 1'b0);

        // ----------------------------------------
        // receive init, one class at a time
        // ----------------------------------------
        wait_init_level(1'b1);
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            #1;
            take_snapshot();
            exp_hdr[c]  = init_hdr[c];
            exp_data[c] = init_data[c];
            rx_hcrdt_init_ack_i[c] = 1'b1;
            rx_dcrdt_init_ack_i[c] = 1'b1;
            @(posedge clk);
            #1;
            rx_hcrdt_init_ack_i = '0;
            rx_dcrdt_init_ack_i = '0;
            wait_returns_done();
            check_returns();
        end
        check_bit("rx_hcrdt_init_o held", &rx_hcrdt_init_o, 1'b1);  // rx_ready_i still low
        rx_ready_i = 1'b1;
        wait_init_level(1'b0);

        // runtime returns for reads and writes
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            len = (rnd[9:0] == 10'd0) ? 10'd1 : rnd[9:0];
            @(posedge clk);
            #1;
            take_snapshot();
            exp_hdr[int'(rt_class[i])] = 16'd1;
            if (rt_is_wr[i]) begin
                exp_data[crdt_pkg::P] = crdt_pkg::ctr_t'((int'(len) + 3) / 4);
            end
            hdr_valid_i = 1'b1;
            hdr_is_rd_i = !rt_is_wr[i];
            hdr_is_wr_i = rt_is_wr[i];
            hdr_len_i   = len;
            @(posedge clk);
            #1;
            hdr_valid_i = 1'b0;
            wait_returns_done();
            check_returns();
            got_class = crdt_pkg::P;
            for (int c = 0; c < 3; c++) begin
                if (hdr_sum[c] != hdr_base[c]) begin
                    got_class = crdt_pkg::crdt_class_e'(c[1:0]);
                end
            end
            check_state_class("header return class", got_class, rt_class[i]);
        end

        // ----------------------------------------
        // transmit grants, acks and consumption
        // ----------------------------------------
        @(posedge clk);
        #1;
        pio_tx_ready_i  = 1'b1;
        tx_hcrdt_init_i = 3'b111;
        tx_dcrdt_init_i = 3'b111;
        take_snapshot();
        for (int g = 0; g < 2; g++) begin
            apply_grant(gr_hupd[g], gr_hcnt[g], gr_dupd[g], gr_dcnt[g]);
        end
        check_acks(6'b111111);
        tx_hcrdt_init_i = '0;
        tx_dcrdt_init_i = '0;
        wait_tx_ready(1'b1);
        check_bit("tx_ready_o", tx_ready_o, expect_ready());
        for (int k = 0; k < 3; k++) begin
            send_and_check(cpl_len[k]);
        end
        check_bit("tx_ready_o after CPL drain", tx_ready_o, 1'b0);

        // zero-count grant under init makes both CPL channels infinite
        @(posedge clk);
        #1;
        tx_hcrdt_init_i = 3'b100;
        tx_dcrdt_init_i = 3'b100;
        take_snapshot();
        apply_grant(3'b100, 6'd0, 3'b100, 12'd0);
        check_acks(6'b100100);
        tx_hcrdt_init_i = '0;
        tx_dcrdt_init_i = '0;
        wait_tx_ready(1'b1);
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            send_and_check(rnd[9:0]);
        end

        check_count("oversized return chunks", oversize_chunks, 16'd0);
        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verification
common/crdt_pkg.sv
rx_credit/rx_credit_fsm.sv
rx_credit/rx_credit_return.sv
tx_credit/tx_consume_calc.sv
tx_credit/tx_credit_channel.sv
tx_credit/tx_ready_gen.sv
verilog/crdt_intf_top.sv
verification/crdt_intf_tb.sv

// File: verilog/crdt_intf_top.sv
`timescale 1ns/100ps

module crdt_intf_top #(
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_p_data   = 8'd85,
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_np_data  = 8'd85,
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_cpl_data = 8'd85,
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_p_hdr    = 8'd11,
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_np_hdr   = 8'd11,
    parameter logic [crdt_pkg::init_ctr_w-1:0] init_rx_cpl_hdr  = 8'd10
) (
    input  logic        clk,
    input  logic        srst_reg,

    // receive credit init and return
    output logic [2:0]  rx_hcrdt_init_o,
    output logic [2:0]  rx_dcrdt_init_o,
    input  logic [2:0]  rx_hcrdt_init_ack_i,
    input  logic [2:0]  rx_dcrdt_init_ack_i,
    output logic [2:0]  rx_hcrdt_update_o,
    output logic [5:0]  rx_hcrdt_update_cnt_o,
    output logic [2:0]  rx_dcrdt_update_o,
    output logic [11:0] rx_dcrdt_update_cnt_o,

    // accepted request headers
    input  logic        hdr_valid_i,
    input  logic        hdr_is_rd_i,
    input  logic        hdr_is_wr_i,
    input  logic [9:0]  hdr_len_i,
    input  logic        rx_ready_i,

    // transmit credit grants
    input  logic [2:0]  tx_hcrdt_update_i,
    input  logic [5:0]  tx_hcrdt_update_cnt_i,
    input  logic [2:0]  tx_dcrdt_update_i,
    input  logic [11:0] tx_dcrdt_update_cnt_i,
    input  logic [2:0]  tx_hcrdt_init_i,
    input  logic [2:0]  tx_dcrdt_init_i,
    output logic [2:0]  tx_hcrdt_init_ack_o,
    output logic [2:0]  tx_dcrdt_init_ack_o,

    // sent completions
    input  logic        tx_hdr_valid_i,
    input  logic [9:0]  tx_hdr_len_i,
    input  logic        pio_tx_ready_i,
    output logic        tx_ready_o
);

    localparam int nc = crdt_pkg::num_classes;
    localparam int nch = crdt_pkg::num_channels;
    localparam int hw = crdt_pkg::hdr_cnt_w;
    localparam int dw = crdt_pkg::data_cnt_w;

    crdt_pkg::rx_state_e        rx_state;
    logic                       all_empty;
    crdt_pkg::ctr_t [nch-1:0]   consume;
    logic [nch-1:0]             chan_update;
    logic [nch-1:0]             chan_init;
    logic [nch-1:0]             chan_ack;
    logic [nch-1:0]             chan_low;
    logic [nch-1:0][dw-1:0]     chan_cnt;

    // channel order is P, NP, CPL headers then P, NP, CPL data
    assign chan_update         = {tx_dcrdt_update_i, tx_hcrdt_update_i};
    assign chan_init           = {tx_dcrdt_init_i, tx_hcrdt_init_i};
    assign tx_hcrdt_init_ack_o = chan_ack[nc-1:0];
    assign tx_dcrdt_init_ack_o = chan_ack[nch-1:nc];

    rx_credit_fsm i_rx_fsm (
        .clk           (clk),
        .srst_reg      (srst_reg),
        .rx_ready_i    (rx_ready_i),
        .all_empty_i   (all_empty),
        .tx_init_any_i (|chan_init),
        .rx_state_o    (rx_state)
    );

    rx_credit_return #(
        .init_rx_p_data   (init_rx_p_data),
        .init_rx_np_data  (init_rx_np_data),
        .init_rx_cpl_data (init_rx_cpl_data),
        .init_rx_p_hdr    (init_rx_p_hdr),
        .init_rx_np_hdr   (init_rx_np_hdr),
        .init_rx_cpl_hdr  (init_rx_cpl_hdr)
    ) i_rx_return (
        .clk                   (clk),
        .srst_reg              (srst_reg),
        .rx_state_i            (rx_state),
        .rx_hcrdt_init_ack_i   (rx_hcrdt_init_ack_i),
        .rx_dcrdt_init_ack_i   (rx_dcrdt_init_ack_i),
        .hdr_valid_i           (hdr_valid_i),
        .hdr_is_rd_i           (hdr_is_rd_i),
        .hdr_is_wr_i           (hdr_is_wr_i),
        .hdr_len_i             (hdr_len_i),
        .rx_hcrdt_init_o       (rx_hcrdt_init_o),
        .rx_dcrdt_init_o       (rx_dcrdt_init_o),
        .rx_hcrdt_update_o     (rx_hcrdt_update_o),
        .rx_hcrdt_update_cnt_o (rx_hcrdt_update_cnt_o),
        .rx_dcrdt_update_o     (rx_dcrdt_update_o),
        .rx_dcrdt_update_cnt_o (rx_dcrdt_update_cnt_o),
        .all_empty_o           (all_empty)
    );

    tx_consume_calc i_consume (
        .clk            (clk),
        .srst_reg       (srst_reg),
        .tx_hdr_valid_i (tx_hdr_valid_i),
        .tx_hdr_len_i   (tx_hdr_len_i),
        .consume_o      (consume)
    );

    for (genvar ch = 0; ch < nch; ch++) begin : g_chan
        if (ch < nc) begin : g_hdr
            assign chan_cnt[ch] = {{(dw-hw){1'b0}}, tx_hcrdt_update_cnt_i[ch*hw +: hw]};
        end else begin : g_data
            assign chan_cnt[ch] = tx_dcrdt_update_cnt_i[(ch-nc)*dw +: dw];
        end

        tx_credit_channel i_chan (
            .clk          (clk),
            .srst_reg     (srst_reg),
            .update_i     (chan_update[ch]),
            .update_cnt_i (chan_cnt[ch]),
            .init_i       (chan_init[ch]),
            .consume_i    (consume[ch]),
            .init_ack_o   (chan_ack[ch]),
            .credit_low_o (chan_low[ch])
        );
    end

    tx_ready_gen i_ready (
        .clk            (clk),
        .srst_reg       (srst_reg),
        .credit_low_i   (chan_low),
        .pio_tx_ready_i (pio_tx_ready_i),
        .tx_ready_o     (tx_ready_o)
    );

endmodule
